// ==== design/motorPwmPkg.sv ====
package motorPwmPkg;

    // step length and step counter width, enough for a few seconds of clocks
    localparam int STEP_W = 25;

    // period length and on-time values
    localparam int LEN_W = 12;

    // want and real accumulators, and the lost report
    localparam int ACC_W = 16;

    // one electrical cycle is split into twelve sub-steps
    localparam int SUB_STEPS = 12;

    // each phase drives for half of the electrical cycle
    localparam int DRIVE_STEPS = 6;

    // phases B and C trail phase A by one third of the cycle each
    localparam int PHASE_SHIFT = 4;

    // shortest pulse the gate driver switches cleanly, in clocks
    localparam int MIN_PULSE = 16;

    // sub-step index, zero to SUB_STEPS minus one
    typedef logic [3:0] stepIdxT;

    // on-time or period length in clocks
    typedef logic [LEN_W-1:0] lenT;

    // accumulated on-time over one step
    typedef logic [ACC_W-1:0] accT;

endpackage

// ==== design/stepTimer.sv ====
`timescale 1ns/1ps

module stepTimer
    import motorPwmPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    input  logic [STEP_W-1:0] stepLen,
    output logic              stepFirst,
    output logic              stepLast
);

    // clock count within the current commutation step
    logic [STEP_W-1:0] stepCnt;
    logic              cntAtFirst;
    logic              cntAtLast;

    assign cntAtFirst = (stepCnt == '0);
    assign cntAtLast  = (stepCnt == stepLen - 1'b1);

    // strobes only exist while stepping is enabled
    assign stepFirst = run && cntAtFirst;
    assign stepLast  = run && cntAtLast;

    // counts 0 .. stepLen-1 and wraps, so a step lasts exactly stepLen clocks
    always_ff @(posedge clk) begin
        if (reset) begin
            stepCnt <= '0;
        end else if (!run) begin
            // parked at zero so the next run starts with a full step
            stepCnt <= '0;
        end else if (cntAtLast) begin
            stepCnt <= '0;
        end else begin
            stepCnt <= stepCnt + 1'b1;
        end
    end

endmodule

// ==== design/commutationSequencer.sv ====
`timescale 1ns/1ps

module commutationSequencer
    import motorPwmPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    stepLast,
    input  lenT     dutyLen,
    output stepIdxT stepIdx,
    output logic    driveEnA,
    output logic    driveEnB,
    output logic    driveEnC,
    output lenT     wantLenA,
    output lenT     wantLenB,
    output lenT     wantLenC
);

    stepIdxT nextIdx;
    logic    nextDriveA;
    logic    nextDriveB;
    logic    nextDriveC;

    // true when the sub-step falls in the drive window of the given phase
    function automatic logic inWindow(input stepIdxT idx, input int unsigned phase);
        logic [4:0] shifted;
        shifted = 5'(idx) + 5'(SUB_STEPS) - 5'(phase * PHASE_SHIFT);
        if (shifted >= 5'(SUB_STEPS)) begin
            shifted = shifted - 5'(SUB_STEPS);
        end
        return (shifted < 5'(DRIVE_STEPS));
    endfunction

    // index moves on at the end of every step and wraps after the last sub-step
    always_comb begin
        nextIdx = stepIdx;
        if (stepLast) begin
            if (stepIdx == stepIdxT'(SUB_STEPS - 1)) begin
                nextIdx = '0;
            end else begin
                nextIdx = stepIdx + 1'b1;
            end
        end
    end

    assign nextDriveA = inWindow(nextIdx, 0);
    assign nextDriveB = inWindow(nextIdx, 1);
    assign nextDriveC = inWindow(nextIdx, 2);

    // drive enables and wanted on-time are registered from the next index,
    // so they switch in the same cycle as stepIdx
    always_ff @(posedge clk) begin
        if (reset) begin
            stepIdx  <= '0;
            driveEnA <= inWindow('0, 0);
            driveEnB <= inWindow('0, 1);
            driveEnC <= inWindow('0, 2);
            wantLenA <= '0;
            wantLenB <= '0;
            wantLenC <= '0;
        end else begin
            stepIdx  <= nextIdx;
            driveEnA <= nextDriveA;
            driveEnB <= nextDriveB;
            driveEnC <= nextDriveC;
            wantLenA <= nextDriveA ? dutyLen : '0;
            wantLenB <= nextDriveB ? dutyLen : '0;
            wantLenC <= nextDriveC ? dutyLen : '0;
        end
    end

endmodule

// ==== design/pwmGenerator.sv ====
`timescale 1ns/1ps

module pwmGenerator
    import motorPwmPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic stepFirst,
    input  logic stepLast,
    input  logic driveEn,
    input  lenT  wantLen,
    input  lenT  periodLen,
    output logic pwm,
    output accT  lost,
    output logic reportValid
);

    // period down-counter, zero while idle between steps
    lenT periodCnt;

    // on-time held back because it was shorter than MIN_PULSE
    lenT remain;

    // cycles left in the pulse being driven
    lenT pulseCnt;

    // remainder plus this period's want, as seen at a boundary
    lenT remainBase;
    lenT pendSum;

    logic boundary;
    logic launch;

    // wanted and delivered on-time over the current step
    accT wantAcc;
    accT realAcc;
    accT realNow;
    accT diff;
    accT lostMag;

    // a new period starts at stepFirst and whenever the counter reaches one.
    // a reload in the stepLast cycle would only start a pulse that is cut
    // right away, so it is not treated as a boundary
    assign boundary = stepFirst || ((periodCnt == lenT'(1)) && !stepLast);

    // the carried remainder belongs to the previous step once stepFirst arrives
    assign remainBase = stepFirst ? '0 : remain;
    assign pendSum    = remainBase + wantLen;

    // pulse only when the gathered on-time is long enough to switch safely
    assign launch = boundary && driveEn && (pendSum >= lenT'(MIN_PULSE));

    assign pwm = (pulseCnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            periodCnt <= '0;
        end else if (stepLast) begin
            periodCnt <= '0;
        end else if (boundary) begin
            periodCnt <= periodLen;
        end else if (periodCnt != '0) begin
            periodCnt <= periodCnt - 1'b1;
        end
    end

    // too-short want is carried into the next period until it reaches MIN_PULSE
    always_ff @(posedge clk) begin
        if (reset) begin
            remain <= '0;
        end else if (boundary && driveEn) begin
            if (launch) begin
                remain <= '0;
            end else begin
                remain <= pendSum;
            end
        end else if (stepFirst) begin
            remain <= '0;
        end
    end

    // pwm rises the cycle after a launching boundary and is dropped after stepLast
    always_ff @(posedge clk) begin
        if (reset) begin
            pulseCnt <= '0;
        end else if (stepLast) begin
            pulseCnt <= '0;
        end else if (launch) begin
            pulseCnt <= pendSum;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wantAcc <= '0;
        end else if (stepFirst) begin
            // stepFirst is itself a boundary, so its want is loaded directly
            wantAcc <= driveEn ? accT'(wantLen) : '0;
        end else if (boundary && driveEn) begin
            wantAcc <= wantAcc + accT'(wantLen);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            realAcc <= '0;
        end else if (stepFirst) begin
            realAcc <= '0;
        end else if (pwm) begin
            realAcc <= realAcc + 1'b1;
        end
    end

    // the stepLast cycle itself may still be a pwm-high cycle
    assign realNow = realAcc + accT'(pwm);
    assign diff    = wantAcc - realNow;

    // lost is reported as a magnitude, the sign is not kept
    assign lostMag = diff[ACC_W-1] ? (~diff + 1'b1) : diff;

    always_ff @(posedge clk) begin
        if (reset) begin
            reportValid <= 1'b0;
            lost        <= '0;
        end else begin
            reportValid <= stepLast;
            if (stepLast) begin
                lost <= lostMag;
            end
        end
    end

endmodule

// ==== design/motorPwmTop.sv ====
`timescale 1ns/1ps

module motorPwmTop
    import motorPwmPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    input  logic [STEP_W-1:0] stepLen,
    input  lenT               periodLen,
    input  lenT               dutyLen,
    output logic              pwmA,
    output logic              pwmB,
    output logic              pwmC,
    output stepIdxT           stepIdx,
    output logic              reportValid,
    output accT               lostA,
    output accT               lostB,
    output accT               lostC
);

    logic stepFirst;
    logic stepLast;
    logic driveEnA;
    logic driveEnB;
    logic driveEnC;
    lenT  wantLenA;
    lenT  wantLenB;
    lenT  wantLenC;

    stepTimer stepTimer_i (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .stepLen   (stepLen),
        .stepFirst (stepFirst),
        .stepLast  (stepLast)
    );

    commutationSequencer commutationSequencer_i (
        .clk      (clk),
        .reset    (reset),
        .stepLast (stepLast),
        .dutyLen  (dutyLen),
        .stepIdx  (stepIdx),
        .driveEnA (driveEnA),
        .driveEnB (driveEnB),
        .driveEnC (driveEnC),
        .wantLenA (wantLenA),
        .wantLenB (wantLenB),
        .wantLenC (wantLenC)
    );

    // all three phases report on the same cycle, phase A stands for them
    pwmGenerator pwmGeneratorA_i (
        .clk         (clk),
        .reset       (reset),
        .stepFirst   (stepFirst),
        .stepLast    (stepLast),
        .driveEn     (driveEnA),
        .wantLen     (wantLenA),
        .periodLen   (periodLen),
        .pwm         (pwmA),
        .lost        (lostA),
        .reportValid (reportValid)
    );

    pwmGenerator pwmGeneratorB_i (
        .clk         (clk),
        .reset       (reset),
        .stepFirst   (stepFirst),
        .stepLast    (stepLast),
        .driveEn     (driveEnB),
        .wantLen     (wantLenB),
        .periodLen   (periodLen),
        .pwm         (pwmB),
        .lost        (lostB),
        .reportValid ()
    );

    pwmGenerator pwmGeneratorC_i (
        .clk         (clk),
        .reset       (reset),
        .stepFirst   (stepFirst),
        .stepLast    (stepLast),
        .driveEn     (driveEnC),
        .wantLen     (wantLenC),
        .periodLen   (periodLen),
        .pwm         (pwmC),
        .lost        (lostC),
        .reportValid ()
    );

endmodule

// ==== tb/motorPwm_sva.sv ====
`timescale 1ns/1ps

module motorPwmSva
    import motorPwmPkg::*;
(
    input logic clk,
    input logic reset,
    input logic stepLast,
    input logic driveEn,
    input logic pwm,
    input logic reportValid
);

    // number of rule violations seen so far
    int failCount = 0;

    // length of the current run of pwm-high cycles
    accT highRun;

    always_ff @(posedge clk) begin
        if (reset) begin
            highRun <= '0;
        end else if (pwm) begin
            highRun <= highRun + 1'b1;
        end else begin
            highRun <= '0;
        end
    end

    // a pulse shorter than MIN_PULSE is only legal when the step end cut it
    minPulseWidth: assert property (@(posedge clk) disable iff (reset)
        $fell(pwm) |-> (highRun >= accT'(MIN_PULSE)) || $past(stepLast))
    else begin
        failCount++;
        $error("pwm pulse ended after %0d cycles without a step end", highRun);
    end

    reportAfterLast: assert property (@(posedge clk) disable iff (reset)
        reportValid == $past(stepLast))
    else begin
        failCount++;
        $error("reportValid does not follow stepLast by one cycle");
    end

    // an idle phase with no pulse running never starts one
    idleStaysLow: assert property (@(posedge clk) disable iff (reset)
        (!driveEn && !pwm) |=> !pwm)
    else begin
        failCount++;
        $error("pwm rose while driveEn was low and no pulse was pending");
    end

endmodule

bind pwmGenerator motorPwmSva motorPwmSva_i (
    .clk         (clk),
    .reset       (reset),
    .stepLast    (stepLast),
    .driveEn     (driveEn),
    .pwm         (pwm),
    .reportValid (reportValid)
);

// ==== tb/motorPwmTb.sv ====
`timescale 1ns/1ps

module motorPwmTb
    import motorPwmPkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_TESTS    = 16;
    localparam int FIELDS       = 7;
    localparam int MIN_GAP      = 4;
    localparam int REPORT_WAIT  = 8;

    logic              clk;
    logic              reset;
    logic              run;
    logic [STEP_W-1:0] stepLen;
    lenT               periodLen;
    lenT               dutyLen;
    logic              pwmA;
    logic              pwmB;
    logic              pwmC;
    stepIdxT           stepIdx;
    logic              reportValid;
    accT               lostA;
    accT               lostB;
    accT               lostC;

    // seven words per test, see the header of the vectors file
    logic [31:0] vecMem [0:MAX_TESTS*FIELDS-1];

    integer  seed;
    int      budgetCycles = 0;
    int      reportCount  = 0;
    int      expReports   = 0;
    stepIdxT expIdx       = '0;
    accT     onCnt [0:2]  = '{default: '0};
    int      curName;
    int      curSteps;
    accT     curOn;
    accT     curLost;

    motorPwmTop motorPwmTop_i (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .stepLen     (stepLen),
        .periodLen   (periodLen),
        .dutyLen     (dutyLen),
        .pwmA        (pwmA),
        .pwmB        (pwmB),
        .pwmC        (pwmC),
        .stepIdx     (stepIdx),
        .reportValid (reportValid),
        .lostA       (lostA),
        .lostB       (lostB),
        .lostC       (lostC)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkStepIdx(input int name, input string what, input stepIdxT exp,
                                input stepIdxT act);
        if (act !== exp) begin
            abortRun($sformatf("MISMATCH test %0d %s: expected %0d, actual %0d",
                               name, what, exp, act));
        end
    endtask

    task automatic checkOnTime(input int name, input string what, input accT exp, input accT act);
        if (act !== exp) begin
            abortRun($sformatf("MISMATCH test %0d %s: expected %0d, actual %0d",
                               name, what, exp, act));
        end
    endtask

    task automatic checkLost(input int name, input string what, input accT exp, input accT act);
        if (act !== exp) begin
            abortRun($sformatf("MISMATCH test %0d %s: expected %0d, actual %0d",
                               name, what, exp, act));
        end
    endtask

    // phase p drives while the index shifted back by p thirds of the cycle is in the first half
    function automatic logic phaseDrives(input stepIdxT idx, input int phase);
        int offset;
        offset = (int'(idx) + SUB_STEPS - phase * PHASE_SHIFT) % SUB_STEPS;
        return offset < DRIVE_STEPS;
    endfunction

    // a boundary every periodLen clocks from stepFirst, none on the stepLast cycle
    function automatic accT wantPerStep();
        return accT'(dutyLen) * accT'((stepLen - 2) / periodLen + 1);
    endfunction

    function automatic accT magnitude(input int value);
        return (value < 0) ? accT'(-value) : accT'(value);
    endfunction

    function automatic int svaFailures();
        return motorPwmTop_i.pwmGeneratorA_i.motorPwmSva_i.failCount
             + motorPwmTop_i.pwmGeneratorB_i.motorPwmSva_i.failCount
             + motorPwmTop_i.pwmGeneratorC_i.motorPwmSva_i.failCount;
    endfunction

    task automatic checkReport();
        stepIdxT doneIdx;
        accT     lostVal [0:2];
        logic    driving;
        byte     tag;
        doneIdx = expIdx;
        lostVal = '{lostA, lostB, lostC};
        expIdx  = (expIdx == stepIdxT'(SUB_STEPS - 1)) ? '0 : expIdx + 1'b1;
        checkStepIdx(curName, "stepIdx", expIdx, stepIdx);
        for (int p = 0; p < 3; p++) begin
            driving = phaseDrives(doneIdx, p);
            tag     = 8'd65 + 8'(p);
            checkOnTime(curName, $sformatf("pwm%c on-time", tag), driving ? curOn : '0, onCnt[p]);
            checkLost(curName, $sformatf("lost%c", tag), driving ? curLost : '0, lostVal[p]);
            // the report also has to agree with wanted minus counted on-time
            checkLost(curName, $sformatf("lost%c against count", tag),
                      magnitude(int'(driving ? wantPerStep() : '0) - int'(onCnt[p])), lostVal[p]);
            onCnt[p] = '0;
        end
        reportCount++;
    endtask

    // pwm-high cycles are counted per phase between report strobes
    always @(negedge clk) begin
        if (!reset) begin
            if (svaFailures() != 0) begin
                abortRun("a bound assertion on a PWM generator failed");
            end
            if (reportValid) begin
                checkReport();
            end
            onCnt[0] = onCnt[0] + accT'(pwmA);
            onCnt[1] = onCnt[1] + accT'(pwmB);
            onCnt[2] = onCnt[2] + accT'(pwmC);
        end
    end

    task automatic checkIdle(input int name);
        checkStepIdx(name, "idle stepIdx", expIdx, stepIdx);
        checkOnTime(name, "idle pwmA on-time", '0, onCnt[0]);
        checkOnTime(name, "idle pwmB on-time", '0, onCnt[1]);
        checkOnTime(name, "idle pwmC on-time", '0, onCnt[2]);
        if (reportCount != expReports) begin
            abortRun($sformatf("test %0d: reportValid pulsed while run was low", name));
        end
    endtask

    task automatic runTest(input int idx);
        int base;
        int gap;
        int waited;
        base     = idx * FIELDS;
        curName  = int'(vecMem[base]);
        curSteps = int'(vecMem[base + 4]);
        curOn    = accT'(vecMem[base + 5]);
        curLost  = accT'(vecMem[base + 6]);
        gap      = MIN_GAP + ($random(seed) & 15);
        @(posedge clk);
        #2;
        stepLen   = STEP_W'(vecMem[base + 1]);
        periodLen = lenT'(vecMem[base + 2]);
        dutyLen   = lenT'(vecMem[base + 3]);
        repeat (gap) @(posedge clk);
        #2;
        checkIdle(curName);
        run = 1'b1;
        // every step is exactly stepLen clocks, so run drops in the last report cycle
        repeat (curSteps * int'(stepLen)) @(posedge clk);
        #2;
        run = 1'b0;
        expReports += curSteps;
        waited = 0;
        while (reportCount < expReports && waited < REPORT_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (reportCount != expReports) begin
            abortRun($sformatf("test %0d: %0d step reports expected but %0d seen",
                               curName, expReports, reportCount));
        end
    endtask

    initial begin
        int numTests;
        int budget;
        clk       = 1'b0;
        reset     = 1'b1;
        run       = 1'b0;
        stepLen   = '0;
        periodLen = '0;
        dutyLen   = '0;
        seed      = 92;
        budget    = 0;
        $readmemh("tb/pwmVectors.txt", vecMem);
        numTests = 0;
        while (numTests < MAX_TESTS && !$isunknown(vecMem[numTests * FIELDS])
               && vecMem[numTests * FIELDS] != 0) begin
            budget += int'(vecMem[numTests * FIELDS + 4]) * int'(vecMem[numTests * FIELDS + 1]);
            budget += MIN_GAP + 16 + REPORT_WAIT + 4;
            numTests++;
        end
        if (numTests == 0) begin
            abortRun("no test vectors could be read from tb/pwmVectors.txt");
        end
        budgetCycles = budget + RESET_CYCLES + 100;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        // quiet stretch after reset with run still low
        repeat (10) @(posedge clk);
        #2;
        checkIdle(0);
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        if (svaFailures() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abortRun("bound assertions reported failures");
        end
    end

    initial begin
        wait (budgetCycles != 0);
        #(budgetCycles * CLK_PERIOD);
        abortRun("watchdog expired, the simulation hung before all tests were done");
    end

endmodule

// ==== tb/pwmVectors.txt ====
// name stepLen periodLen dutyLen steps onTime lost, all in hex, one test per line
// onTime and lost hold for driving steps, non-driving steps expect zero for both
01 78 28 14 06 3C 00
02 64 28 14 04 3B 01
03 5A 28 14 05 31 0B
04 C8 20 06 0E 24 06
05 96 1E 0A 07 28 0A
06 40 20 10 03 20 00
07 50 28 00 02 00 00
08 32 20 0F 03 11 0D
09 14 28 14 04 13 01

// ==== compile.f ====
design/motorPwmPkg.sv
design/stepTimer.sv
design/commutationSequencer.sv
design/pwmGenerator.sv
design/motorPwmTop.sv
tb/motorPwm_sva.sv
tb/motorPwmTb.sv
